// ==== csu_sched_consts.svh ====
// Sizing for the CSU issue scheduler
// Commit ids wrap at 2**CSU_CMT_ID_W, so no more than half that range
// may be in flight for the relative-age compare to hold

`ifndef CSU_SCHED_CONSTS_SVH
`define CSU_SCHED_CONSTS_SVH

// Pool and bus sizes
`define CSU_NUM_ENTRIES   4
`define CSU_NUM_OPERANDS  2
`define CSU_WR_BUS_SIZE   2

// Field widths
`define CSU_RNID_W        6
`define CSU_CMT_ID_W      5
`define CSU_CSR_ADDR_W    12
`define CSU_OP_W          3

`endif

// ==== csu_sched_pkg.sv ====
// Types and age helpers shared by the CSU scheduler blocks
// Age is always taken relative to the ROB head, never by raw id compare

`default_nettype none

`include "csu_sched_consts.svh"

package csu_sched_pkg;

  typedef logic [`CSU_RNID_W-1:0]     rnid_t;
  typedef logic [`CSU_CMT_ID_W-1:0]   cmt_id_t;
  typedef logic [`CSU_OP_W-1:0]       csr_op_t;
  typedef logic [`CSU_CSR_ADDR_W-1:0] csr_addr_t;

  typedef struct packed {
    logic  valid;
    logic  ready;
    rnid_t rnid;
  } src_t;

  // Renamed micro-op from dispatch
  typedef struct packed {
    cmt_id_t                          cmt_id;
    logic                             oldest;   // Must be ROB head to issue
    csr_op_t                          op;
    csr_addr_t                        csr_addr;
    rnid_t                            rd_rnid;
    src_t [`CSU_NUM_OPERANDS-1:0]     srcs;
  } disp_t;

  // Payload handed to the execution unit
  typedef struct packed {
    cmt_id_t                          cmt_id;
    csr_op_t                          op;
    csr_addr_t                        csr_addr;
    rnid_t                            rd_rnid;
    rnid_t [`CSU_NUM_OPERANDS-1:0]    rs_rnid;
  } issue_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } phy_wr_t;

  typedef struct packed {
    logic    valid;
    logic    flush;     // Exception, kills everything
    cmt_id_t cmt_id;
  } commit_t;

  typedef struct packed {
    logic    update;
    logic    mispredict;
    cmt_id_t cmt_id;
  } br_upd_t;

  typedef enum logic [1:0] {
    INIT   = 2'd0,
    WAIT   = 2'd1,
    ISSUED = 2'd2
  } sched_state_t;

  // Distance from the head, wraps with the id
  function automatic cmt_id_t rel_age(input cmt_id_t id, input cmt_id_t head);
    cmt_id_t diff;
    diff = id - head;
    return diff;
  endfunction

  // Younger than a mispredicted branch
  function automatic logic is_br_flush_target(input cmt_id_t id, input cmt_id_t head,
                                              input br_upd_t br);
    return br.update & br.mispredict & (rel_age(id, head) > rel_age(br.cmt_id, head));
  endfunction

endpackage

`default_nettype wire

// ==== csu_issue_entry.sv ====
// One CSU scheduler slot cycling INIT -> WAIT -> ISSUED -> INIT
// Wakeup is registered, so a write-bus hit can issue no earlier than the
// following cycle. Payload is only meaningful while the slot is not INIT

`timescale 1ns/1ps
`default_nettype none

`include "csu_sched_consts.svh"

module csu_issue_entry
  import csu_sched_pkg::*;
(
  input  wire logic                                i_clk,
  input  wire logic                                i_reset_n,

  input  wire logic                                i_put,
  input  wire disp_t                               i_put_data,

  input  wire phy_wr_t [`CSU_WR_BUS_SIZE-1:0]      i_phy_wr,
  input  wire cmt_id_t                             i_rob_head_cmt_id,

  input  wire commit_t                             i_commit,
  input  wire br_upd_t                             i_br_upd,

  input  wire logic                                i_picked,

  output logic                                     o_valid,
  output logic                                     o_ready_req,
  output cmt_id_t                                  o_cmt_id,
  output logic                                     o_issued,
  output issue_t                                   o_issue
);

  sched_state_t r_state;
  sched_state_t w_state_next;
  disp_t        r_data;
  disp_t        w_data_next;

  logic w_entry_flush;
  logic w_put_flush;
  logic w_oldest_ok;
  logic w_srcs_ready;

  // True if any write-bus port produces this rnid
  function automatic logic wr_bus_hit(input rnid_t rnid,
                                      input phy_wr_t [`CSU_WR_BUS_SIZE-1:0] wr);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < `CSU_WR_BUS_SIZE; p++) begin
      hit = hit | (wr[p].valid & (wr[p].rnid == rnid));
    end
    return hit;
  endfunction

  // ----------------------------------------------------------------------
  // Flush detection
  // ----------------------------------------------------------------------
  assign w_entry_flush = (r_state != INIT) &
                         ((i_commit.valid & i_commit.flush) |
                          is_br_flush_target(r_data.cmt_id, i_rob_head_cmt_id, i_br_upd));

  // Op arriving in the same cycle as a flush is dropped on the floor
  assign w_put_flush = (i_commit.valid & i_commit.flush) |
                       is_br_flush_target(i_put_data.cmt_id, i_rob_head_cmt_id, i_br_upd);

  // ----------------------------------------------------------------------
  // Readiness
  // ----------------------------------------------------------------------
  assign w_oldest_ok = ~r_data.oldest | (r_data.cmt_id == i_rob_head_cmt_id);

  always_comb begin
    w_srcs_ready = 1'b1;
    for (int k = 0; k < `CSU_NUM_OPERANDS; k++) begin
      if (r_data.srcs[k].valid & ~r_data.srcs[k].ready) begin
        w_srcs_ready = 1'b0;
      end
    end
  end

  assign o_ready_req = (r_state == WAIT) & ~w_entry_flush & w_srcs_ready & w_oldest_ok;

  // ----------------------------------------------------------------------
  // Payload and wakeup
  // ----------------------------------------------------------------------
  always_comb begin
    w_data_next = r_data;
    if ((r_state == INIT) & i_put) begin
      w_data_next = i_put_data;       // Fresh op gets wakeup below too
    end
    for (int k = 0; k < `CSU_NUM_OPERANDS; k++) begin
      w_data_next.srcs[k].ready = w_data_next.srcs[k].ready |
                                  wr_bus_hit(w_data_next.srcs[k].rnid, i_phy_wr);
    end
  end

  always_ff @(posedge i_clk) begin
    r_data <= w_data_next;
  end

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      INIT: begin
        if (i_put & ~w_put_flush) begin
          w_state_next = WAIT;
        end
      end
      WAIT: begin
        if (w_entry_flush) begin
          w_state_next = INIT;
        end else if (o_ready_req & i_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        w_state_next = INIT;          // Frees itself whether flushed or not
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign o_valid  = (r_state != INIT);
  assign o_cmt_id = r_data.cmt_id;
  assign o_issued = (r_state == ISSUED) & ~w_entry_flush;   // Killed issue is swallowed

  always_comb begin
    o_issue.cmt_id   = r_data.cmt_id;
    o_issue.op       = r_data.op;
    o_issue.csr_addr = r_data.csr_addr;
    o_issue.rd_rnid  = r_data.rd_rnid;
    for (int k = 0; k < `CSU_NUM_OPERANDS; k++) begin
      o_issue.rs_rnid[k] = r_data.srcs[k].rnid;
    end
  end

endmodule

`default_nettype wire

// ==== csu_age_picker.sv ====
// Oldest-first select among requesting scheduler entries
// Pure combinational; equal ages (should not occur) fall back to lowest index
// Nothing is granted while the execution unit stalls

`timescale 1ns/1ps
`default_nettype none

`include "csu_sched_consts.svh"

module csu_age_picker
  import csu_sched_pkg::*;
(
  input  wire logic [`CSU_NUM_ENTRIES-1:0]     i_req,
  input  wire cmt_id_t [`CSU_NUM_ENTRIES-1:0]  i_cmt_id,
  input  wire cmt_id_t                         i_rob_head_cmt_id,
  input  wire logic                            i_stall,
  output logic [`CSU_NUM_ENTRIES-1:0]          o_grant
);

  cmt_id_t [`CSU_NUM_ENTRIES-1:0] w_age;
  logic    [`CSU_NUM_ENTRIES-1:0] w_beaten;

  // Distance from ROB head per entry
  always_comb begin
    for (int i = 0; i < `CSU_NUM_ENTRIES; i++) begin
      w_age[i] = rel_age(i_cmt_id[i], i_rob_head_cmt_id);
    end
  end

  // ----------------------------------------------------------------------
  // Pairwise compare where an entry loses to any older requester
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `CSU_NUM_ENTRIES; i++) begin
      w_beaten[i] = 1'b0;
      for (int j = 0; j < `CSU_NUM_ENTRIES; j++) begin
        if (j != i) begin
          if (i_req[j] & (w_age[j] < w_age[i])) begin
            w_beaten[i] = 1'b1;
          end
          // Tie break on index
          if (i_req[j] & (w_age[j] == w_age[i]) & (j < i)) begin
            w_beaten[i] = 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `CSU_NUM_ENTRIES; i++) begin
      o_grant[i] = i_req[i] & ~w_beaten[i] & ~i_stall;
    end
  end

endmodule

`default_nettype wire

// ==== csu_issue_sched.sv ====
// CSU issue scheduler top with entry pool, allocation and oldest-first pick
// Dispatch is accepted on any edge with o_disp_ready high and no handshake back
// Issue output is combinational from the entry in ISSUED, one per cycle

`timescale 1ns/1ps
`default_nettype none

`include "csu_sched_consts.svh"

module csu_issue_sched
  import csu_sched_pkg::*;
(
  input  wire logic                             i_clk,
  input  wire logic                             i_reset_n,

  // Dispatch
  input  wire logic                             i_disp_valid,
  input  wire disp_t                            i_disp,
  output logic                                  o_disp_ready,

  // Wakeup and ordering
  input  wire phy_wr_t [`CSU_WR_BUS_SIZE-1:0]   i_phy_wr,
  input  wire cmt_id_t                          i_rob_head_cmt_id,

  // Flush sources
  input  wire commit_t                          i_commit,
  input  wire br_upd_t                          i_br_upd,

  // Execution unit side
  input  wire logic                             i_issue_stall,
  output logic                                  o_issue_valid,
  output issue_t                                o_issue
);

  logic    [`CSU_NUM_ENTRIES-1:0] w_entry_valid;
  logic    [`CSU_NUM_ENTRIES-1:0] w_entry_req;
  logic    [`CSU_NUM_ENTRIES-1:0] w_entry_issued;
  cmt_id_t [`CSU_NUM_ENTRIES-1:0] w_entry_cmt_id;
  issue_t  [`CSU_NUM_ENTRIES-1:0] w_entry_issue;

  logic    [`CSU_NUM_ENTRIES-1:0] w_free;
  logic    [`CSU_NUM_ENTRIES-1:0] w_alloc_sel;
  logic    [`CSU_NUM_ENTRIES-1:0] w_put;
  logic    [`CSU_NUM_ENTRIES-1:0] w_grant;
  logic                           w_disp_fire;

  // ----------------------------------------------------------------------
  // Allocation
  // ----------------------------------------------------------------------
  assign w_free       = ~w_entry_valid;
  assign o_disp_ready = |w_free;
  assign w_disp_fire  = i_disp_valid & o_disp_ready;

  // Lowest index free slot wins
  always_comb begin
    logic found;
    found       = 1'b0;
    w_alloc_sel = '0;
    for (int i = 0; i < `CSU_NUM_ENTRIES; i++) begin
      if (w_free[i] & ~found) begin
        w_alloc_sel[i] = 1'b1;
        found          = 1'b1;
      end
    end
  end

  assign w_put = w_alloc_sel & {`CSU_NUM_ENTRIES{w_disp_fire}};

  // ----------------------------------------------------------------------
  // Entry pool
  // ----------------------------------------------------------------------
  generate
    for (genvar e = 0; e < `CSU_NUM_ENTRIES; e++) begin : g_entry
      csu_issue_entry u_entry (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_put             (w_put[e]),
        .i_put_data        (i_disp),          // Same op offered to all and one takes it
        .i_phy_wr          (i_phy_wr),
        .i_rob_head_cmt_id (i_rob_head_cmt_id),
        .i_commit          (i_commit),
        .i_br_upd          (i_br_upd),
        .i_picked          (w_grant[e]),
        .o_valid           (w_entry_valid[e]),
        .o_ready_req       (w_entry_req[e]),
        .o_cmt_id          (w_entry_cmt_id[e]),
        .o_issued          (w_entry_issued[e]),
        .o_issue           (w_entry_issue[e])
      );
    end
  endgenerate

  // ----------------------------------------------------------------------
  // Pick
  // ----------------------------------------------------------------------
  csu_age_picker u_picker (
    .i_req             (w_entry_req),
    .i_cmt_id          (w_entry_cmt_id),
    .i_rob_head_cmt_id (i_rob_head_cmt_id),
    .i_stall           (i_issue_stall),
    .o_grant           (w_grant)
  );

  // ----------------------------------------------------------------------
  // Issue output
  // ----------------------------------------------------------------------
  // At most one entry sits in ISSUED since only one grant per cycle
  assign o_issue_valid = |w_entry_issued;

  // AND-OR mux over the one-hot issued vector
  always_comb begin
    o_issue = '0;
    for (int i = 0; i < `CSU_NUM_ENTRIES; i++) begin
      o_issue = o_issue | (w_entry_issue[i] & {$bits(issue_t){w_entry_issued[i]}});
    end
  end

endmodule

`default_nettype wire

// ==== csu_sched_properties.sv ====
// Protocol checks bound onto the CSU issue scheduler top
// Flush checks look one cycle back, at the head and branch of the flush cycle

`timescale 1ns/1ps
`default_nettype none

module csu_sched_properties
  import csu_sched_pkg::*;
(
  input wire logic    i_clk,
  input wire logic    i_reset_n,
  input wire logic    i_issue_stall,
  input wire commit_t i_commit,
  input wire br_upd_t i_br_upd,
  input wire cmt_id_t i_rob_head_cmt_id,
  input wire logic    o_disp_ready,
  input wire logic    o_issue_valid,
  input wire issue_t  o_issue
);

  // Nothing granted in a stalled cycle, so nothing shows the cycle after
  a_no_issue_after_stall : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      i_issue_stall |=> !o_issue_valid
  ) else $error("issue seen in the cycle after a stalled cycle");

  a_reset_state : assert property (
    @(posedge i_clk) $rose(i_reset_n) |-> (o_disp_ready && !o_issue_valid)
  ) else $error("wrong dispatch-ready or issue-valid level right after reset");

  a_no_issue_after_commit_flush : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      (i_commit.valid && i_commit.flush) |=> !o_issue_valid
  ) else $error("issue seen right after a flushing commit");

  // Younger than the mispredicted branch, ages taken from the old head
  a_no_issue_after_br_flush : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      (i_br_upd.update && i_br_upd.mispredict) |=>
        !(o_issue_valid &&
          (cmt_id_t'(o_issue.cmt_id - $past(i_rob_head_cmt_id)) >
           cmt_id_t'($past(i_br_upd.cmt_id) - $past(i_rob_head_cmt_id))))
  ) else $error("issued cmt_id was killed by a branch mispredict");

endmodule

bind csu_issue_sched csu_sched_properties u_props (
  .i_clk             (i_clk),
  .i_reset_n         (i_reset_n),
  .i_issue_stall     (i_issue_stall),
  .i_commit          (i_commit),
  .i_br_upd          (i_br_upd),
  .i_rob_head_cmt_id (i_rob_head_cmt_id),
  .o_disp_ready      (o_disp_ready),
  .o_issue_valid     (o_issue_valid),
  .o_issue           (o_issue)
);

`default_nettype wire

// ==== tb_csu_issue_sched.sv ====
// Directed testbench for the CSU issue scheduler
// Latencies count rising edges from the edge that drives the stimulus
// Strobes (dispatch, write bus, commit, branch) last one cycle

`timescale 1ns/1ps
`default_nettype none

`include "csu_sched_consts.svh"

module tb_csu_issue_sched
  import csu_sched_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int SAMPLED_LAT = 2;    // Registered input plus the pick edge
  localparam int COMB_LAT    = 1;    // Head and stall act on the grant directly
  localparam int TEST_CYCLES = 60;   // Generous bound for one test
  localparam int NUM_TESTS   = 6;
  localparam int TIMEOUT_NS  = (NUM_TESTS * TEST_CYCLES + 50) * CLK_PERIOD;

  logic                           i_clk;
  logic                           i_reset_n;
  logic                           i_disp_valid;
  disp_t                          i_disp;
  logic                           o_disp_ready;
  phy_wr_t [`CSU_WR_BUS_SIZE-1:0] i_phy_wr;
  cmt_id_t                        i_rob_head_cmt_id;
  commit_t                        i_commit;
  br_upd_t                        i_br_upd;
  logic                           i_issue_stall;
  logic                           o_issue_valid;
  issue_t                         o_issue;

  int     errors;
  int     checks;
  int     tests;
  issue_t issued_q[$];

  csu_issue_sched dut (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ---------------------------------------------------------------------
  // Compare and report
  // ---------------------------------------------------------------------
  task automatic check_issue(input string name, input issue_t got, input issue_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("t=%0t %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("Test %0d %-8s %s", tests, name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  task automatic step();   // One edge with strobes dropped
    @(posedge i_clk);
    i_disp_valid <= 1'b0;
    i_phy_wr     <= '0;
    i_commit     <= '0;
    i_br_upd     <= '0;
  endtask

  task automatic dispatch_op(input disp_t op);
    @(negedge i_clk);
    if (!o_disp_ready) begin
      report_failure("dispatch blocked, no free entry");
    end
    step();
    i_disp_valid <= 1'b1;
    i_disp       <= op;
  endtask

  task automatic wake(input rnid_t rnid);
    step();
    i_phy_wr[1].valid <= 1'b1;
    i_phy_wr[1].rnid  <= rnid;
  endtask

  task automatic set_head(input int id);
    step();
    i_rob_head_cmt_id <= cmt_id_t'(id);
  endtask

  function automatic disp_t make_op(input int id, input logic oldest, input logic pend,
                                    input rnid_t pend_rnid);
    disp_t op;
    op.cmt_id        = cmt_id_t'(id);
    op.oldest        = oldest;
    op.op            = csr_op_t'($urandom_range(7, 1));
    op.csr_addr      = csr_addr_t'($urandom);
    op.rd_rnid       = rnid_t'($urandom);
    op.srcs[0].valid = 1'b1;
    op.srcs[0].ready = ~pend;
    op.srcs[0].rnid  = pend ? pend_rnid : rnid_t'($urandom);
    op.srcs[1].valid = 1'b1;
    op.srcs[1].ready = 1'b1;
    op.srcs[1].rnid  = rnid_t'($urandom);
    return op;
  endfunction

  // Issue payload is the op minus its flags and ready bits
  function automatic issue_t to_issue(input disp_t op);
    issue_t iss;
    iss.cmt_id     = op.cmt_id;
    iss.op         = op.op;
    iss.csr_addr   = op.csr_addr;
    iss.rd_rnid    = op.rd_rnid;
    iss.rs_rnid[0] = op.srcs[0].rnid;
    iss.rs_rnid[1] = op.srcs[1].rnid;
    return iss;
  endfunction

  task automatic expect_issue(input int exp_lat, input disp_t op);
    int lat;
    lat = 0;
    while (lat < 10) begin
      step();
      lat++;
      @(negedge i_clk);
      if (o_issue_valid) begin
        break;
      end
    end
    if (!o_issue_valid) begin
      report_failure("no issue within 10 cycles");
    end else begin
      if (lat != exp_lat) begin
        report_failure($sformatf("issue after %0d edges, expected %0d", lat, exp_lat));
      end
      check_issue("o_issue", o_issue, to_issue(op));
    end
  endtask

  task automatic collect_issues(input int cycles);
    issued_q.delete();
    repeat (cycles) begin
      step();
      @(negedge i_clk);
      if (o_issue_valid) begin
        issued_q.push_back(o_issue);
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------
  task automatic test_ready_ops();
    int    e0;
    disp_t op;
    e0 = errors;
    op = make_op(5, 1'b0, 1'b0, '0);
    dispatch_op(op);
    expect_issue(SAMPLED_LAT, op);
    step();
    @(negedge i_clk);
    check_bit("o_issue_valid", o_issue_valid, 1'b0);   // Single cycle pulse
    finish_test("ready", e0);
  endtask

  task automatic test_wakeup();
    int    e0;
    rnid_t r;
    disp_t op;
    e0 = errors;
    r  = rnid_t'($urandom);
    op = make_op(6, 1'b0, 1'b1, r);
    dispatch_op(op);
    collect_issues(4);
    if (issued_q.size() != 0) begin
      report_failure("op with a pending source issued");
    end
    wake(r);
    expect_issue(SAMPLED_LAT, op);
    finish_test("wakeup", e0);
  endtask

  task automatic test_oldest();
    int    e0;
    disp_t op;
    e0 = errors;
    set_head(3);
    op = make_op(7, 1'b1, 1'b0, '0);
    dispatch_op(op);
    collect_issues(4);
    if (issued_q.size() != 0) begin
      report_failure("oldest op issued before it was the ROB head");
    end
    set_head(7);
    expect_issue(COMB_LAT, op);
    finish_test("oldest", e0);
  endtask

  task automatic test_age_stall();
    int    e0;
    int    ids[4]   = '{1, 30, 3, 31};
    int    order[4] = '{1, 3, 0, 2};   // Ages from head 30 are 3, 0, 5, 1
    disp_t ops[4];
    e0 = errors;
    set_head(30);
    step();
    i_issue_stall <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      ops[k] = make_op(ids[k], 1'b0, 1'b0, '0);
      dispatch_op(ops[k]);
    end
    step();
    @(negedge i_clk);
    check_bit("o_disp_ready", o_disp_ready, 1'b0);
    collect_issues(3);
    if (issued_q.size() != 0) begin
      report_failure("op issued while the execution unit stalled");
    end
    step();
    i_issue_stall <= 1'b0;
    expect_issue(COMB_LAT, ops[order[0]]);
    for (int k = 1; k < 4; k++) begin
      step();
      @(negedge i_clk);
      check_bit("o_issue_valid", o_issue_valid, 1'b1);
      check_issue("o_issue", o_issue, to_issue(ops[order[k]]));
    end
    finish_test("age", e0);
  endtask

  task automatic test_br_flush();
    int    e0;
    rnid_t r;
    disp_t ops[4];
    e0 = errors;
    set_head(10);
    r = rnid_t'($urandom);
    for (int k = 0; k < 4; k++) begin
      ops[k] = make_op(11 + k, 1'b0, 1'b1, r);
      dispatch_op(ops[k]);
    end
    step();
    i_br_upd.update     <= 1'b1;
    i_br_upd.mispredict <= 1'b1;
    i_br_upd.cmt_id     <= cmt_id_t'(12);   // Kills 13 and 14
    step();
    @(negedge i_clk);
    check_bit("o_disp_ready", o_disp_ready, 1'b1);
    wake(r);
    collect_issues(8);
    if (issued_q.size() != 2) begin
      report_failure($sformatf("%0d ops issued after branch flush, expected 2",
                               issued_q.size()));
    end else begin
      check_issue("o_issue", issued_q[0], to_issue(ops[0]));
      check_issue("o_issue", issued_q[1], to_issue(ops[1]));
    end
    finish_test("branch", e0);
  endtask

  task automatic test_commit_flush();
    int    e0;
    rnid_t r;
    disp_t ops[4];
    e0 = errors;
    set_head(0);
    r = rnid_t'($urandom);
    for (int k = 0; k < 4; k++) begin
      ops[k] = make_op(1 + k, 1'b0, 1'b1, r);
      dispatch_op(ops[k]);
    end
    step();
    i_commit.valid <= 1'b1;
    i_commit.flush <= 1'b1;
    step();
    @(negedge i_clk);
    check_bit("o_disp_ready", o_disp_ready, 1'b1);   // Pool was full before the flush
    wake(r);
    collect_issues(8);
    if (issued_q.size() != 0) begin
      report_failure("op issued after a flushing commit");
    end
    finish_test("commit", e0);
  endtask

  // ---------------------------------------------------------------------
  // Run control
  // ---------------------------------------------------------------------
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(32'ha46e_8d0f));
    errors            = 0;
    checks            = 0;
    tests             = 0;
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_disp_valid      = 1'b0;
    i_disp            = '0;
    i_phy_wr          = '0;
    i_rob_head_cmt_id = '0;
    i_commit          = '0;
    i_br_upd          = '0;
    i_issue_stall     = 1'b0;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;
    step();
    test_ready_ops();
    test_wakeup();
    test_oldest();
    test_age_stall();
    test_br_flush();
    test_commit_flush();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
csu_sched_pkg.sv
csu_issue_entry.sv
csu_age_picker.sv
csu_issue_sched.sv
csu_sched_properties.sv
tb_csu_issue_sched.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSU issue scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_csu_issue_sched \
  --Mdir obj_dir -o tb_csu_issue_sched

status=0
./obj_dir/tb_csu_issue_sched > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
